//--- verilog.f
+incdir+verilog
verilog/priv_pkg.sv
verilog/cache_op_if.sv
verilog/priv_issue.sv
verilog/cacop_channel.sv
verilog/priv_retire.sv
verilog/exe_priv.sv
testbench/exe_priv_sva.sv
testbench/exe_priv_tb.sv

//--- testbench/exe_priv_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "priv_consts.svh"

module exe_priv_tb
    import priv_pkg::*;
();

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] result;
        logic [13:0] csr_addr;
        logic [31:0] csr_wen;
        logic [31:0] csr_wdata;
        logic [31:0] vaddr;
        logic [1:0]  level;
        logic [1:0]  code;
        logic [6:0]  exp;
        logic [31:0] badv;
        logic [4:0]  rd;
        logic        ertn;
        logic        query;
    } expect_t;

    logic clk, rstn, flush_by_writeback, en_in;
    priv_op_t op;
    logic [31:0] inst, pc_next, sr0, sr1, imm, era, csr_rdata;
    logic [4:0] addr_in, addr_out;
    logic en_out, flush, stall, csr_query_en, restore_state, llbit_clear;
    logic [31:0] pc_target, result, badv_out, csr_wen, csr_wdata;
    logic [6:0] exp_out;
    logic [13:0] csr_addr;
    logic [2:0] cache_en, cache_ready, cache_complete;
    logic [1:0] cache_code [3];
    logic [31:0] cache_vaddr [3];
    logic [6:0] cache_exp [3];
    logic [31:0] cache_badv [3];

    logic [31:0] lfsr;
    int errors = 0;
    int checks = 0;
    int cycle = 0;
    int retire_due, restore_seen, llbit_seen, query_seen;
    bit pending, retired, en_prev;
    string test_name;
    priv_op_t cur_op;
    expect_t exp_r;

    exe_priv u_exe_priv (.*);

    // csr file model, every address reads a distinct word
    function automatic logic [31:0] csr_model(input logic [13:0] a);
        return {a, 4'h9, a} ^ 32'h3c5a_96e1;
    endfunction

    assign csr_rdata = csr_model(csr_addr);

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hb4bc_d35c) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // expected retire from the operands alone
    function automatic expect_t predict_retire(input priv_op_t o, input logic [31:0] iw,
            input logic [31:0] s0, input logic [31:0] s1, input logic [31:0] im,
            input logic [31:0] pc, input logic [31:0] ra, input logic [4:0] rd,
            input logic [6:0] cexp, input logic [31:0] cbadv);
        expect_t e;
        e = '0;
        e.pc = (o == OP_ERTN) ? ra : pc;
        e.csr_addr = im[13:0];
        e.csr_wdata = s1;
        e.csr_wen = (iw[9:5] == 5'd1) ? 32'hffff_ffff : s0;
        e.result = (o == OP_CSR) ? csr_model(im[13:0]) : 32'h0;
        e.vaddr = s0 + im;
        e.code = iw[4:3];
        e.level = (iw[1:0] == 2'd3) ? 2'd2 : iw[1:0];
        e.exp = (o == OP_CACOP) ? cexp : 7'h0;
        e.badv = (o == OP_CACOP) ? cbadv : 32'h0;
        e.rd = rd;
        e.ertn = (o == OP_ERTN);
        e.query = (o == OP_CSR);
        return e;
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle = cycle + 1;

    // compare process, mid-cycle so every output has settled
    always @(negedge clk) begin
        if (rstn) begin
            if (restore_state) restore_seen++;
            if (llbit_clear) llbit_seen++;
            if (csr_query_en) query_seen++;
            if (!en_out && (exp_out != '0 || badv_out != '0)) begin
                $display("Fail %s exp/badv outside retire expected 0/0 actual %h/%h",
                         test_name, exp_out, badv_out);
                errors++;
            end
            if (en_out && en_prev) begin
                $display("en_out held for more than one cycle");
                errors++;
            end
            if (en_out && !pending) begin
                $display("en_out with no instruction in flight");
                errors++;
            end else if (en_out) begin
                checks++;
                retired = 1'b1;
                if (!flush) begin
                    $display("retire of %s came without flush", test_name);
                    errors++;
                end
                if (cycle != retire_due)
                    $display("Fail %s retire edge expected %0d actual %0d",
                             test_name, retire_due, cycle);
                if (cycle != retire_due) errors++;
                if (pc_target != exp_r.pc) begin
                    $display("Fail %s pc_target expected %h actual %h",
                             test_name, exp_r.pc, pc_target);
                    errors++;
                end
                if (result != exp_r.result) begin
                    $display("Fail %s result expected %h actual %h",
                             test_name, exp_r.result, result);
                    errors++;
                end
                if (exp_out != exp_r.exp || badv_out != exp_r.badv) begin
                    $display("Fail %s exp/badv expected %h/%h actual %h/%h",
                             test_name, exp_r.exp, exp_r.badv, exp_out, badv_out);
                    errors++;
                end
                if (addr_out != exp_r.rd) begin
                    $display("Fail %s addr_out expected %h actual %h",
                             test_name, exp_r.rd, addr_out);
                    errors++;
                end
                if (cur_op == OP_CSR && (csr_addr != exp_r.csr_addr ||
                        csr_wen != exp_r.csr_wen || csr_wdata != exp_r.csr_wdata)) begin
                    $display("Fail %s csr addr/wen/wdata expected %h/%h/%h actual %h/%h/%h",
                             test_name, exp_r.csr_addr, exp_r.csr_wen, exp_r.csr_wdata,
                             csr_addr, csr_wen, csr_wdata);
                    errors++;
                end
                if (query_seen != int'(exp_r.query)) begin
                    $display("Fail %s csr_query_en pulses expected %0d actual %0d",
                             test_name, exp_r.query, query_seen);
                    errors++;
                end
                if (restore_seen != int'(exp_r.ertn) || llbit_seen != int'(exp_r.ertn)) begin
                    $display("Fail %s restore/llbit pulses expected %0d actual %0d/%0d",
                             test_name, exp_r.ertn, restore_seen, llbit_seen);
                    errors++;
                end
            end
        end
        en_prev = en_out;
    end

    task automatic wait_idle();
        int t;
        t = 0;
        @(posedge clk);
        #2;
        while (stall && t < 200) begin
            @(posedge clk);
            #2;
            t++;
        end
        if (stall) begin
            $display("timeout: unit still stalled before %s", test_name);
            errors++;
        end
    endtask

    task automatic present_complete(input logic [1:0] lvl, input logic [6:0] cexp,
                                    input logic [31:0] cbadv);
        cache_complete[lvl] = 1'b1;
        cache_exp[lvl] = cexp;
        cache_badv[lvl] = cbadv;
        // sampled on the next edge, retire two edges later
        retire_due = cycle + 3;
    endtask

    // plays the cache side of one level
    task automatic serve_cache(input logic [1:0] lvl, input logic [6:0] cexp,
                               input logic [31:0] cbadv, input int hold);
        int t;
        int rdly;
        int cdly;
        rdly = hold + int'(rand_bits(2));
        cdly = int'(rand_bits(2));
        t = 0;
        while (!cache_en[lvl] && t < 50) begin
            @(posedge clk);
            #2;
            t++;
        end
        if (!cache_en[lvl]) begin
            $display("timeout: no cache request on level %0d in %s", lvl, test_name);
            errors++;
            return;
        end
        if ((cache_en & ~(3'b001 << lvl)) != 3'b000) begin
            $display("%s raised a request on a level it did not select", test_name);
            errors++;
        end
        if (cache_code[lvl] != exp_r.code || cache_vaddr[lvl] != exp_r.vaddr) begin
            $display("Fail %s code/vaddr expected %h/%h actual %h/%h", test_name,
                     exp_r.code, exp_r.vaddr, cache_code[lvl], cache_vaddr[lvl]);
            errors++;
        end
        repeat (rdly) begin
            @(posedge clk);
            #2;
            if (!cache_en[lvl] || !stall) begin
                $display("%s let go of the request before ready", test_name);
                errors++;
            end
        end
        cache_ready[lvl] = 1'b1;
        if (cdly == 0) present_complete(lvl, cexp, cbadv);
        @(posedge clk);
        #2;
        cache_ready[lvl] = 1'b0;
        if (cache_en[lvl]) begin
            $display("%s kept cache_en high after ready", test_name);
            errors++;
        end
        if (cdly != 0) begin
            repeat (cdly - 1) begin
                @(posedge clk);
                #2;
            end
            present_complete(lvl, cexp, cbadv);
            @(posedge clk);
            #2;
        end
        // stale values must not leak into the result
        cache_complete[lvl] = 1'b0;
        cache_exp[lvl] = 7'(rand_bits(7));
        cache_badv[lvl] = rand_bits(32);
    endtask

    task automatic run_op(input string name, input priv_op_t o, input logic [31:0] iw,
                          input int hold);
        int t;
        logic [6:0] cexp;
        logic [31:0] cbadv;
        test_name = name;
        wait_idle();
        cexp = 7'(rand_bits(7));
        cbadv = rand_bits(32);
        en_in = 1'b1;
        op = o;
        inst = iw;
        sr0 = rand_bits(32);
        sr1 = rand_bits(32);
        imm = rand_bits(32);
        pc_next = rand_bits(32);
        era = rand_bits(32);
        addr_in = 5'(rand_bits(5));
        exp_r = predict_retire(o, iw, sr0, sr1, imm, pc_next, era, addr_in, cexp, cbadv);
        cur_op = o;
        restore_seen = 0;
        llbit_seen = 0;
        query_seen = 0;
        retired = 1'b0;
        retire_due = -1;
        pending = 1'b1;
        @(posedge clk);
        #2;
        en_in = 1'b0;
        if (!stall) begin
            $display("%s was not accepted", name);
            errors++;
        end
        if (o == OP_CACOP)
            serve_cache(exp_r.level, cexp, cbadv, hold);
        else
            retire_due = cycle + 3;
        t = 0;
        while (!retired && t < 200) begin
            @(posedge clk);
            #2;
            t++;
        end
        if (!retired) begin
            $display("timeout: %s never retired", name);
            errors++;
        end
        pending = 1'b0;
    endtask

    // writeback flush two edges into an instruction
    task automatic abort_op(input string name, input priv_op_t o, input logic [31:0] iw);
        test_name = name;
        wait_idle();
        pending = 1'b0;
        en_in = 1'b1;
        op = o;
        inst = iw;
        sr0 = rand_bits(32);
        imm = rand_bits(32);
        @(posedge clk);
        #2;
        en_in = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        if (o == OP_CACOP && cache_en == 3'b000) begin
            $display("%s raised no cache request before the flush", name);
            errors++;
        end
        flush_by_writeback = 1'b1;
        @(posedge clk);
        #2;
        flush_by_writeback = 1'b0;
        if (stall || cache_en != 3'b000) begin
            $display("%s still busy after writeback flush", name);
            errors++;
        end
        repeat (6) @(posedge clk);
    endtask

    initial begin
        logic [31:0] w;
        lfsr = 32'h97c8_8e20;
        rstn = 1'b0;
        flush_by_writeback = 1'b0;
        en_in = 1'b0;
        op = OP_NONE;
        inst = '0;
        pc_next = '0;
        sr0 = '0;
        sr1 = '0;
        imm = '0;
        era = '0;
        addr_in = '0;
        cache_ready = '0;
        cache_complete = '0;
        for (int l = 0; l < 3; l++) begin
            cache_exp[l] = 7'(rand_bits(7));
            cache_badv[l] = rand_bits(32);
        end
        repeat (10) @(posedge clk);
        #2;
        rstn = 1'b1;
        if (en_out || flush || stall || csr_query_en || restore_state || llbit_clear ||
                cache_en != 3'b000) begin
            $display("control outputs not low after reset");
            errors++;
        end
        for (int i = 0; i < 6; i++) begin
            w = rand_bits(32);
            // even runs are plain csrwr
            if (i % 2 == 0) w[9:5] = 5'd1;
            run_op($sformatf("csr_%0d", i), OP_CSR, w, 0);
        end
        for (int i = 0; i < 3; i++) run_op($sformatf("ertn_%0d", i), OP_ERTN, rand_bits(32), 0);
        for (int i = 0; i < 3; i++) run_op($sformatf("bar_%0d", i), OP_BAR, rand_bits(32), 0);
        for (int s = 0; s < 4; s++) begin
            w = rand_bits(32);
            w[1:0] = s[1:0];
            run_op($sformatf("cacop_sel%0d", s), OP_CACOP, w, 0);
        end
        w = rand_bits(32);
        w[1:0] = 2'd2;
        run_op("cacop_backpressure", OP_CACOP, w, 20);
        for (int i = 0; i < 4; i++) run_op($sformatf("cacop_rand_%0d", i), OP_CACOP,
                                           rand_bits(32), int'(rand_bits(3)));
        abort_op("abort_csr", OP_CSR, rand_bits(32));
        run_op("csr_after_abort", OP_CSR, rand_bits(32), 0);
        w = rand_bits(32);
        w[1:0] = 2'd1;
        abort_op("abort_cacop", OP_CACOP, w);
        run_op("cacop_after_abort", OP_CACOP, w, 1);
        errors = errors + u_exe_priv.u_sva.violations;
        $display("%0d retires checked, %0d errors", checks, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/exe_priv_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "priv_consts.svh"

module exe_priv_sva (
    input logic                     clk,
    input logic                     rstn,
    input logic                     flush_by_writeback,
    input logic                     en_out,
    input logic                     flush,
    input logic                     stall,
    input logic                     csr_query_en,
    input logic                     restore_state,
    input logic                     llbit_clear,
    input logic [`CACHE_LEVELS-1:0] cache_en,
    input logic [`CACHE_LEVELS-1:0] cache_ready
);

    int violations = 0;

    // retire redirects the pipeline and frees the unit
    a_retire_flush: assert property (@(posedge clk) disable iff (!rstn)
        en_out |-> flush && !stall)
        else begin
            $error("en_out seen without flush or with stall high");
            violations++;
        end

    a_retire_pulse: assert property (@(posedge clk) disable iff (!rstn)
        en_out |=> !en_out)
        else begin
            $error("en_out longer than one cycle");
            violations++;
        end

    for (genvar l = 0; l < `CACHE_LEVELS; l++) begin : g_lvl
        // request is withdrawn once the cache has taken it
        a_en_drop: assert property (@(posedge clk) disable iff (!rstn || flush_by_writeback)
            cache_en[l] && cache_ready[l] |=> !cache_en[l])
            else begin
                $error("cache_en held after ready on level %0d", l);
                violations++;
            end
    end

    a_reset_low: assert property (@(posedge clk)
        !rstn |=> !en_out && !flush && !stall && !csr_query_en && !restore_state
                  && !llbit_clear && cache_en == '0)
        else begin
            $error("control outputs not low after reset");
            violations++;
        end

endmodule

bind exe_priv exe_priv_sva u_sva (
    .clk(clk), .rstn(rstn), .flush_by_writeback(flush_by_writeback),
    .en_out(en_out), .flush(flush), .stall(stall), .csr_query_en(csr_query_en),
    .restore_state(restore_state), .llbit_clear(llbit_clear),
    .cache_en(cache_en), .cache_ready(cache_ready)
);

`default_nettype wire

//--- verilog/exe_priv.sv
`timescale 1ns/1ps
`default_nettype none

`include "priv_consts.svh"

module exe_priv
    import priv_pkg::*;
(
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     flush_by_writeback,
    input  logic                     en_in,
    input  priv_op_t                 op,
    input  logic [`PRIV_XLEN-1:0]    inst,
    input  logic [`PRIV_XLEN-1:0]    pc_next,
    input  logic [`PRIV_XLEN-1:0]    sr0,
    input  logic [`PRIV_XLEN-1:0]    sr1,
    input  logic [`PRIV_XLEN-1:0]    imm,
    input  logic [`REG_ADDR_W-1:0]   addr_in,
    output logic                     en_out,
    output logic [`PRIV_XLEN-1:0]    pc_target,
    output logic                     flush,
    output logic                     stall,
    output logic [`PRIV_XLEN-1:0]    result,
    output logic [`REG_ADDR_W-1:0]   addr_out,
    output logic [`EXP_W-1:0]        exp_out,
    output logic [`PRIV_XLEN-1:0]    badv_out,
    // csr file
    output logic                     csr_query_en,
    output logic [`CSR_ADDR_W-1:0]   csr_addr,
    input  logic [`PRIV_XLEN-1:0]    csr_rdata,
    output logic [`PRIV_XLEN-1:0]    csr_wen,
    output logic [`PRIV_XLEN-1:0]    csr_wdata,
    // exception return
    input  logic [`PRIV_XLEN-1:0]    era,
    output logic                     restore_state,
    output logic                     llbit_clear,
    // per-level cache maintenance, index 0 is l1i
    output logic [`CACHE_LEVELS-1:0] cache_en,
    output logic [`CACOP_CODE_W-1:0] cache_code  [`CACHE_LEVELS],
    output logic [`PRIV_XLEN-1:0]    cache_vaddr [`CACHE_LEVELS],
    input  logic [`CACHE_LEVELS-1:0] cache_ready,
    input  logic [`CACHE_LEVELS-1:0] cache_complete,
    input  logic [`EXP_W-1:0]        cache_exp   [`CACHE_LEVELS],
    input  logic [`PRIV_XLEN-1:0]    cache_badv  [`CACHE_LEVELS]
);

    logic                  simple_done;
    logic [`PRIV_XLEN-1:0] simple_result;
    logic                  op_is_csr;

    cache_op_if ch [`CACHE_LEVELS] ();

    priv_issue u_issue (
        .clk(clk), .rstn(rstn), .flush_by_writeback(flush_by_writeback),
        .en_in(en_in), .op(op), .inst(inst), .pc_next(pc_next),
        .sr0(sr0), .sr1(sr1), .imm(imm), .era(era), .addr_in(addr_in),
        .csr_rdata(csr_rdata), .stall(stall), .pc_target(pc_target),
        .addr_out(addr_out), .csr_query_en(csr_query_en), .csr_addr(csr_addr),
        .csr_wen(csr_wen), .csr_wdata(csr_wdata), .restore_state(restore_state),
        .llbit_clear(llbit_clear), .simple_done(simple_done),
        .simple_result(simple_result), .op_is_csr(op_is_csr), .ch(ch)
    );

    for (genvar l = 0; l < `CACHE_LEVELS; l++) begin : g_chan
        cacop_channel u_chan (
            .clk(clk), .rstn(rstn), .flush_by_writeback(flush_by_writeback),
            .cache_en(cache_en[l]), .cache_code(cache_code[l]),
            .cache_vaddr(cache_vaddr[l]), .cache_ready(cache_ready[l]),
            .cache_complete(cache_complete[l]), .cache_exp(cache_exp[l]),
            .cache_badv(cache_badv[l]), .op(ch[l])
        );
    end

    priv_retire u_retire (
        .clk(clk), .rstn(rstn), .flush_by_writeback(flush_by_writeback),
        .simple_done(simple_done), .simple_result(simple_result),
        .op_is_csr(op_is_csr), .ch(ch), .en_out(en_out), .flush(flush),
        .result(result), .exp_out(exp_out), .badv_out(badv_out)
    );

endmodule

`default_nettype wire

//--- verilog/priv_retire.sv
`timescale 1ns/1ps
`default_nettype none

`include "priv_consts.svh"

module priv_retire
    import priv_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  flush_by_writeback,
    input  logic                  simple_done,
    input  logic [`PRIV_XLEN-1:0] simple_result,
    input  logic                  op_is_csr,
    cache_op_if.retire            ch [`CACHE_LEVELS],
    output logic                  en_out,
    output logic                  flush,
    output logic [`PRIV_XLEN-1:0] result,
    output logic [`EXP_W-1:0]     exp_out,
    output logic [`PRIV_XLEN-1:0] badv_out
);

    logic [`CACHE_LEVELS-1:0] ch_done;
    logic [`EXP_W-1:0]        ch_exp  [`CACHE_LEVELS];
    logic [`PRIV_XLEN-1:0]    ch_badv [`CACHE_LEVELS];
    cache_sel_t               done_lvl;
    logic                     cache_done;

    for (genvar l = 0; l < `CACHE_LEVELS; l++) begin : g_ch
        assign ch_done[l] = ch[l].done;
        assign ch_exp[l]  = ch[l].exp;
        assign ch_badv[l] = ch[l].badv;
    end

    // at most one channel completes, pick it
    always_comb begin
        done_lvl = '0;
        for (int i = 0; i < `CACHE_LEVELS; i++) begin
            if (ch_done[i])
                done_lvl = cache_sel_t'(i);
        end
    end

    assign cache_done = |ch_done;

    always_ff @(posedge clk) begin
        if (!rstn || flush_by_writeback) begin
            en_out   <= 1'b0;
            flush    <= 1'b0;
            result   <= '0;
            exp_out  <= '0;
            badv_out <= '0;
        end else begin
            en_out   <= simple_done || cache_done;
            flush    <= simple_done || cache_done;
            result   <= (simple_done && op_is_csr) ? simple_result : '0;
            exp_out  <= cache_done ? ch_exp[done_lvl] : '0;
            badv_out <= cache_done ? ch_badv[done_lvl] : '0;
        end
    end

endmodule

`default_nettype wire

//--- verilog/cacop_channel.sv
`timescale 1ns/1ps
`default_nettype none

`include "priv_consts.svh"

module cacop_channel (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     flush_by_writeback,
    output logic                     cache_en,
    output logic [`CACOP_CODE_W-1:0] cache_code,
    output logic [`PRIV_XLEN-1:0]    cache_vaddr,
    input  logic                     cache_ready,
    input  logic                     cache_complete,
    input  logic [`EXP_W-1:0]        cache_exp,
    input  logic [`PRIV_XLEN-1:0]    cache_badv,
    cache_op_if.channel              op
);

    typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT, S_DONE} state_t;

    state_t                state;
    logic                  done_q;
    logic [`EXP_W-1:0]     exp_q;
    logic [`PRIV_XLEN-1:0] badv_q;

    assign op.done = done_q;
    assign op.exp  = exp_q;
    assign op.badv = badv_q;

    // request payload and outcome, meaningful only with en / done
    always_ff @(posedge clk) begin
        if (state == S_IDLE && op.start) begin
            cache_code  <= op.code;
            cache_vaddr <= op.vaddr;
        end
        if ((state == S_REQ && cache_ready || state == S_WAIT) && cache_complete) begin
            exp_q  <= cache_exp;
            badv_q <= cache_badv;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn || flush_by_writeback) begin
            state    <= S_IDLE;
            cache_en <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (op.start) begin
                        cache_en <= 1'b1;
                        state    <= S_REQ;
                    end
                end
                // en held until the cache takes it, complete may come along
                S_REQ: begin
                    if (cache_ready) begin
                        cache_en <= 1'b0;
                        state    <= cache_complete ? S_DONE : S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (cache_complete)
                        state <= S_DONE;
                end
                S_DONE: begin
                    done_q <= 1'b1;
                    state  <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/priv_issue.sv
`timescale 1ns/1ps
`default_nettype none

`include "priv_consts.svh"

module priv_issue
    import priv_pkg::*;
(
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     flush_by_writeback,
    input  logic                     en_in,
    input  priv_op_t                 op,
    input  logic [`PRIV_XLEN-1:0]    inst,
    input  logic [`PRIV_XLEN-1:0]    pc_next,
    input  logic [`PRIV_XLEN-1:0]    sr0,
    input  logic [`PRIV_XLEN-1:0]    sr1,
    input  logic [`PRIV_XLEN-1:0]    imm,
    input  logic [`PRIV_XLEN-1:0]    era,
    input  logic [`REG_ADDR_W-1:0]   addr_in,
    input  logic [`PRIV_XLEN-1:0]    csr_rdata,
    output logic                     stall,
    output logic [`PRIV_XLEN-1:0]    pc_target,
    output logic [`REG_ADDR_W-1:0]   addr_out,
    output logic                     csr_query_en,
    output logic [`CSR_ADDR_W-1:0]   csr_addr,
    output logic [`PRIV_XLEN-1:0]    csr_wen,
    output logic [`PRIV_XLEN-1:0]    csr_wdata,
    output logic                     restore_state,
    output logic                     llbit_clear,
    output logic                     simple_done,
    output logic [`PRIV_XLEN-1:0]    simple_result,
    output logic                     op_is_csr,
    cache_op_if.issue                ch [`CACHE_LEVELS]
);

    typedef enum logic [2:0] {S_IDLE, S_EXEC, S_FINISH, S_RETIRE, S_CACHE} state_t;

    state_t                   state;
    priv_op_t                 op_q;
    inst_word_u               inst_q;
    logic [`PRIV_XLEN-1:0]    pc_next_q;
    logic [`PRIV_XLEN-1:0]    sr0_q;
    logic [`PRIV_XLEN-1:0]    sr1_q;
    logic [`PRIV_XLEN-1:0]    imm_q;
    logic [`PRIV_XLEN-1:0]    era_q;
    logic                     start_q;
    cache_sel_t               lvl_q;
    logic [`CACOP_CODE_W-1:0] code_q;
    logic [`PRIV_XLEN-1:0]    vaddr_q;
    logic [`CACHE_LEVELS-1:0] ch_done;
    logic                     accept;

    assign accept    = en_in && (state == S_IDLE);
    assign stall     = (state != S_IDLE);
    assign op_is_csr = (op_q == OP_CSR);

    for (genvar l = 0; l < `CACHE_LEVELS; l++) begin : g_ch
        assign ch[l].start = start_q && (lvl_q == cache_sel_t'(l));
        assign ch[l].code  = code_q;
        assign ch[l].vaddr = vaddr_q;
        assign ch_done[l]  = ch[l].done;
    end

    // operands held for the whole instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q      <= op;
            inst_q    <= inst;
            pc_next_q <= pc_next;
            sr0_q     <= sr0;
            sr1_q     <= sr1;
            imm_q     <= imm;
            era_q     <= era;
            addr_out  <= addr_in;
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_EXEC) begin
            pc_target <= (op_q == OP_ERTN) ? era_q : pc_next_q;
            csr_addr  <= imm_q[`CSR_ADDR_W-1:0];
            csr_wdata <= sr1_q;
            // rj == 1 means csrwr, everything else is masked xchg
            csr_wen   <= (inst_q.csr.rj == 5'd1) ? '1 : sr0_q;
            code_q    <= inst_q.cacop.code;
            vaddr_q   <= sr0_q + imm_q;
            if (int'(inst_q.cacop.sel) >= `CACHE_LEVELS)
                lvl_q <= cache_sel_t'(`CACHE_LEVELS - 1);
            else
                lvl_q <= inst_q.cacop.sel;
        end
        // csr file answers combinationally during the query
        if (state == S_FINISH)
            simple_result <= csr_rdata;
    end

    always_ff @(posedge clk) begin
        if (!rstn || flush_by_writeback) begin
            state         <= S_IDLE;
            start_q       <= 1'b0;
            csr_query_en  <= 1'b0;
            restore_state <= 1'b0;
            llbit_clear   <= 1'b0;
            simple_done   <= 1'b0;
        end else begin
            start_q     <= 1'b0;
            simple_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (accept)
                        state <= S_EXEC;
                end
                S_EXEC: begin
                    csr_query_en  <= (op_q == OP_CSR);
                    restore_state <= (op_q == OP_ERTN);
                    llbit_clear   <= (op_q == OP_ERTN);
                    if (op_q == OP_CACOP) begin
                        start_q <= 1'b1;
                        state   <= S_CACHE;
                    end else begin
                        state <= S_FINISH;
                    end
                end
                S_FINISH: begin
                    csr_query_en  <= 1'b0;
                    restore_state <= 1'b0;
                    llbit_clear   <= 1'b0;
                    simple_done   <= 1'b1;
                    state         <= S_RETIRE;
                end
                // retire registers en_out on this edge
                S_RETIRE: state <= S_IDLE;
                S_CACHE: begin
                    if (ch_done[lvl_q])
                        state <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/cache_op_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "priv_consts.svh"

interface cache_op_if;

    // one-cycle launch, only while the channel is idle
    logic                     start;
    logic [`CACOP_CODE_W-1:0] code;
    logic [`PRIV_XLEN-1:0]    vaddr;

    // one-cycle completion, exp and badv valid with it
    logic                     done;
    logic [`EXP_W-1:0]        exp;
    logic [`PRIV_XLEN-1:0]    badv;

    modport issue (output start, output code, output vaddr, input done);

    modport channel (
        input  start, input code, input vaddr,
        output done, output exp, output badv
    );

    modport retire (input done, input exp, input badv);

endinterface

`default_nettype wire

//--- verilog/priv_pkg.sv
`default_nettype none

package priv_pkg;

`include "priv_consts.svh"

    // kept privileged operations
    typedef enum logic [2:0] {
        OP_NONE,
        OP_CSR,
        OP_ERTN,
        OP_CACOP,
        OP_BAR
    } priv_op_t;

    // csr instruction view, rj selects full-word write
    typedef struct packed {
        logic [`PRIV_XLEN-1:10] upper;
        logic [4:0]             rj;
        logic [4:0]             rd;
    } csr_fields_t;

    // cacop instruction view
    typedef struct packed {
        logic [`PRIV_XLEN-1:5]    upper;
        logic [`CACOP_CODE_W-1:0] code;
        logic                     rsvd;
        logic [1:0]               sel;
    } cacop_fields_t;

    // one word, two decodes
    typedef union packed {
        logic [`PRIV_XLEN-1:0] raw;
        csr_fields_t           csr;
        cacop_fields_t         cacop;
    } inst_word_u;

    // channel index, select 3 lands on l2
    typedef logic [1:0] cache_sel_t;

endpackage

`default_nettype wire

//--- verilog/priv_consts.svh
`ifndef PRIV_CONSTS_SVH
`define PRIV_CONSTS_SVH

// data and address width
`define PRIV_XLEN 32

// csr number width, taken from imm
`define CSR_ADDR_W 14

// destination register index
`define REG_ADDR_W 5

// exception code width
`define EXP_W 7

// icache, dcache and l2
`define CACHE_LEVELS 3

// cacop code, inst bits 4..3
`define CACOP_CODE_W 2

`endif
